//--- ldpc_pkg.sv
package ldpc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Code geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int CIRC      = 31;
	localparam int BLK_ROWS  = 3;
	localparam int BLK_COLS  = 5;
	localparam int CODE_LEN  = BLK_COLS * CIRC;
	localparam int NUM_EDGES = BLK_ROWS * BLK_COLS;
	localparam int STEP_W    = 5;
	localparam int ITER_W    = 5;
	localparam int MAX_ITER  = 30;

	// Q8.8 messages, with two guard bits for the node sums
	localparam int MSG_W   = 16;
	localparam int ACC_W   = MSG_W + 2;
	localparam int MSG_MAX = 2 ** (MSG_W - 1) - 1;
	localparam int LLR_MAG = 11;

	// Circulant offsets, powers of 2 and 5 mod 31
	localparam logic [STEP_W-1:0] shift_table [BLK_ROWS][BLK_COLS] = '{
		'{5'd1, 5'd2, 5'd4, 5'd8, 5'd16},
		'{5'd5, 5'd10, 5'd20, 5'd9, 5'd18},
		'{5'd25, 5'd19, 5'd7, 5'd14, 5'd28}
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic signed [MSG_W-1:0] msg_t;

	typedef struct packed {
		msg_t [BLK_ROWS-1:0][BLK_COLS-1:0] m;
	} msg_bundle_t;

	// Edge (i, j) sits at bit i*BLK_COLS + j
	typedef logic [NUM_EDGES-1:0] edge_bits_t;
	typedef logic [CODE_LEN-1:0] codeword_t;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_SYND,
		PH_VAR,
		PH_CHK
	} phase_t;

	typedef struct packed {
		phase_t            phase;
		logic [STEP_W-1:0] rd_step;
		logic              wr_en;
		logic [STEP_W-1:0] wr_step;
	} sweep_ctrl_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Index arithmetic mod CIRC
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [STEP_W-1:0] circ_add(input logic [STEP_W-1:0] a,
			input logic [STEP_W-1:0] b);
		logic [STEP_W:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		if (sum >= (STEP_W+1)'(CIRC))
			sum = sum - (STEP_W+1)'(CIRC);
		return sum[STEP_W-1:0];
	endfunction

	function automatic logic [STEP_W-1:0] circ_sub(input logic [STEP_W-1:0] a,
			input logic [STEP_W-1:0] b);
		logic [STEP_W:0] diff;
		diff = {1'b0, a} + (STEP_W+1)'(CIRC) - {1'b0, b};
		if (diff >= (STEP_W+1)'(CIRC))
			diff = diff - (STEP_W+1)'(CIRC);
		return diff[STEP_W-1:0];
	endfunction

endpackage

//--- phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer
	import ldpc_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              row_fail,
	output sweep_ctrl_t       ctrl,
	output logic              busy,
	output logic              done,
	output logic              success,
	output logic [ITER_W-1:0] iterations
);

	phase_t            phase;
	phase_t            next_phase;
	logic              finish;
	logic              rd_act;
	logic [STEP_W-1:0] rd_step;
	logic              rd_valid;
	logic [STEP_W-1:0] step_d1;
	logic              wr_en;
	logic [STEP_W-1:0] wr_step;
	logic              synd_fail;
	logic              sweep_end;
	logic              sweep_begin;

	// Last write-back of the sweep
	assign sweep_end = wr_en && (wr_step == STEP_W'(CIRC - 1));

	// Every new sweep enters a different phase
	assign sweep_begin = (next_phase != phase) && (next_phase != PH_IDLE);

	always_comb begin
		ctrl.phase   = phase;
		ctrl.rd_step = rd_step;
		ctrl.wr_en   = wr_en;
		ctrl.wr_step = wr_step;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase transitions and stop rule
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		next_phase = phase;
		finish = 1'b0;
		if (phase == PH_IDLE) begin
			if (start)
				next_phase = PH_SYND;
		end else if (sweep_end) begin
			case (phase)
				PH_SYND: begin
					if (synd_fail)
						next_phase = PH_VAR;
					else
						finish = 1'b1;
				end
				PH_VAR:
					next_phase = PH_CHK;
				default: begin
					if (synd_fail && iterations != ITER_W'(MAX_ITER - 1))
						next_phase = PH_VAR;
					else
						finish = 1'b1;
				end
			endcase
		end
		if (finish)
			next_phase = PH_IDLE;
	end

	// Read step, then memory latency, then write-back
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_act   <= 1'b0;
			rd_step  <= '0;
			rd_valid <= 1'b0;
			step_d1  <= '0;
			wr_en    <= 1'b0;
			wr_step  <= '0;
		end else begin
			rd_valid <= rd_act;
			step_d1  <= rd_step;
			wr_en    <= rd_valid;
			wr_step  <= step_d1;
			if (sweep_begin) begin
				rd_act  <= 1'b1;
				rd_step <= '0;
			end else if (rd_act) begin
				if (rd_step == STEP_W'(CIRC - 1))
					rd_act <= 1'b0;
				else
					rd_step <= rd_step + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase      <= PH_IDLE;
			busy       <= 1'b0;
			done       <= 1'b0;
			success    <= 1'b0;
			iterations <= '0;
			synd_fail  <= 1'b0;
		end else begin
			phase <= next_phase;
			done  <= finish;
			if (phase == PH_IDLE && start) begin
				busy       <= 1'b1;
				success    <= 1'b0;
				iterations <= '0;
			end
			if (finish) begin
				busy    <= 1'b0;
				success <= !synd_fail;
			end
			if (sweep_end && phase == PH_CHK)
				iterations <= iterations + 1'b1;
			// Sticky syndrome over the rows of one sweep
			if (sweep_begin)
				synd_fail <= 1'b0;
			else if (rd_valid && (phase == PH_SYND || phase == PH_CHK))
				synd_fail <= synd_fail | row_fail;
		end
	end

endmodule

//--- edge_memory.sv
`timescale 1ns/1ps

module edge_memory
	import ldpc_pkg::*;
(
	input  logic        clk,
	input  sweep_ctrl_t ctrl,
	input  msg_bundle_t v2c,
	input  msg_bundle_t c2v,
	output msg_bundle_t rd_msgs
);

	// One bank per circulant, edge stored at its check row
	for (genvar i = 0; i < BLK_ROWS; i++) begin : g_row
		for (genvar j = 0; j < BLK_COLS; j++) begin : g_col
			msg_t              bank [CIRC];
			logic [STEP_W-1:0] rd_addr;
			logic [STEP_W-1:0] wr_addr;
			msg_t              wr_data;

			// Column sweep walks back along the circulant diagonal
			always_comb begin
				if (ctrl.phase == PH_VAR) begin
					rd_addr = circ_sub(ctrl.rd_step, shift_table[i][j]);
					wr_addr = circ_sub(ctrl.wr_step, shift_table[i][j]);
				end else begin
					rd_addr = ctrl.rd_step;
					wr_addr = ctrl.wr_step;
				end
			end

			// SYND sweep clears the messages of the previous word
			always_comb begin
				case (ctrl.phase)
					PH_VAR:  wr_data = v2c.m[i][j];
					PH_CHK:  wr_data = c2v.m[i][j];
					default: wr_data = '0;
				endcase
			end

			always_ff @(posedge clk) begin
				if (ctrl.wr_en)
					bank[wr_addr] <= wr_data;
				rd_msgs.m[i][j] <= bank[rd_addr];
			end
		end
	end

endmodule

//--- variable_node_unit.sv
`timescale 1ns/1ps

module variable_node_unit
	import ldpc_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  codeword_t   word_in,
	input  sweep_ctrl_t ctrl,
	input  msg_bundle_t c2v,
	output msg_bundle_t v2c,
	output edge_bits_t  bits,
	output codeword_t   decoded
);

	codeword_t          recv;
	logic               load;
	logic [BLK_COLS-1:0] ch_bit_q;
	logic [BLK_COLS-1:0] hard_next;
	logic [BLK_COLS-1:0] hard_q;
	msg_bundle_t        v2c_next;

	assign load = start && (ctrl.phase == PH_IDLE);

	// Symmetric clip keeps the check node magnitudes in range
	function automatic msg_t saturate(input logic signed [ACC_W-1:0] x);
		if (x > MSG_MAX)
			return msg_t'(MSG_MAX);
		if (x < -MSG_MAX)
			return msg_t'(-MSG_MAX);
		return x[MSG_W-1:0];
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Five variable nodes, one column each
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		logic signed [ACC_W-1:0] chan;
		logic signed [ACC_W-1:0] in_msg [BLK_ROWS];
		logic signed [ACC_W-1:0] total;
		for (int j = 0; j < BLK_COLS; j++) begin
			chan = ch_bit_q[j] ? -ACC_W'(LLR_MAG) : ACC_W'(LLR_MAG);
			total = chan;
			for (int i = 0; i < BLK_ROWS; i++) begin
				in_msg[i] = $signed(c2v.m[i][j]);
				total = total + in_msg[i];
			end
			hard_next[j] = total[ACC_W-1];
			// Extrinsic message leaves out the edge's own input
			for (int i = 0; i < BLK_ROWS; i++)
				v2c_next.m[i][j] = saturate(total - in_msg[i]);
		end
	end

	// Channel bits line up with the read data one cycle later
	always_ff @(posedge clk) begin
		if (load)
			recv <= word_in;
		for (int j = 0; j < BLK_COLS; j++)
			ch_bit_q[j] <= recv[j * CIRC + int'(ctrl.rd_step)];
		v2c    <= v2c_next;
		hard_q <= hard_next;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			decoded <= '0;
		end else if (load) begin
			decoded <= word_in;
		end else if (ctrl.phase == PH_VAR && ctrl.wr_en) begin
			for (int j = 0; j < BLK_COLS; j++)
				decoded[j * CIRC + int'(ctrl.wr_step)] <= hard_q[j];
		end
	end

	// Hard decisions seen by the checks of the current row
	always_comb begin
		for (int i = 0; i < BLK_ROWS; i++) begin
			for (int j = 0; j < BLK_COLS; j++)
				bits[i * BLK_COLS + j] =
					decoded[j * CIRC + int'(circ_add(ctrl.rd_step, shift_table[i][j]))];
		end
	end

endmodule

//--- check_node_unit.sv
`timescale 1ns/1ps

module check_node_unit
	import ldpc_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  sweep_ctrl_t ctrl,
	input  msg_bundle_t v2c,
	input  edge_bits_t  bits,
	output msg_bundle_t c2v,
	output logic        row_fail
);

	msg_bundle_t c2v_next;
	logic        parity_fail;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Min-sum over the five edges of a row
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		msg_t                m;
		logic [MSG_W-1:0]    mag [BLK_COLS];
		logic [BLK_COLS-1:0] sgn;
		logic [MSG_W-1:0]    min1;
		logic [MSG_W-1:0]    min2;
		logic [MSG_W-1:0]    out_mag;
		int                  min_idx;
		logic                sign_all;
		for (int i = 0; i < BLK_ROWS; i++) begin
			min1 = '1;
			min2 = '1;
			min_idx = 0;
			sign_all = 1'b0;
			for (int j = 0; j < BLK_COLS; j++) begin
				m = v2c.m[i][j];
				sgn[j] = m[MSG_W-1];
				mag[j] = sgn[j] ? -m : m;
				sign_all = sign_all ^ sgn[j];
				if (mag[j] < min1) begin
					min2 = min1;
					min1 = mag[j];
					min_idx = j;
				end else if (mag[j] < min2) begin
					min2 = mag[j];
				end
			end
			// Smallest of the other four is min2 only at the minimum itself
			for (int j = 0; j < BLK_COLS; j++) begin
				out_mag = (j == min_idx) ? min2 : min1;
				c2v_next.m[i][j] = (sign_all ^ sgn[j]) ? -out_mag : out_mag;
			end
		end
	end

	always_comb begin
		parity_fail = 1'b0;
		for (int i = 0; i < BLK_ROWS; i++)
			parity_fail = parity_fail | (^bits[i * BLK_COLS +: BLK_COLS]);
	end

	always_ff @(posedge clk) begin
		if (ctrl.phase == PH_CHK)
			c2v <= c2v_next;
	end

	// Lines up with the read data of the same row
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			row_fail <= 1'b0;
		else
			row_fail <= parity_fail;
	end

endmodule

//--- ldpc_decoder.sv
`timescale 1ns/1ps

module ldpc_decoder
	import ldpc_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  codeword_t         word_in,
	output logic              busy,
	output logic              done,
	output logic              success,
	output logic [ITER_W-1:0] iterations,
	output codeword_t         decoded
);

	sweep_ctrl_t ctrl;
	msg_bundle_t rd_msgs;
	msg_bundle_t v2c_wr;
	msg_bundle_t c2v_wr;
	edge_bits_t  bits;
	logic        row_fail;

	phase_sequencer u_seq (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.row_fail   (row_fail),
		.ctrl       (ctrl),
		.busy       (busy),
		.done       (done),
		.success    (success),
		.iterations (iterations)
	);

	edge_memory u_mem (
		.clk     (clk),
		.ctrl    (ctrl),
		.v2c     (v2c_wr),
		.c2v     (c2v_wr),
		.rd_msgs (rd_msgs)
	);

	// Read port carries c2v in the VAR sweep and v2c in the CHK sweep
	variable_node_unit u_vnu (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.word_in (word_in),
		.ctrl    (ctrl),
		.c2v     (rd_msgs),
		.v2c     (v2c_wr),
		.bits    (bits),
		.decoded (decoded)
	);

	check_node_unit u_cnu (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.v2c      (rd_msgs),
		.bits     (bits),
		.c2v      (c2v_wr),
		.row_fail (row_fail)
	);

endmodule

//--- ldpc_checker.sv
`timescale 1ns/1ps

module ldpc_checker
	import ldpc_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              busy,
	input  logic              done,
	input  logic              success,
	input  logic [ITER_W-1:0] iterations,
	input  codeword_t         decoded,
	output int                error_count
);

	localparam int CW_LATENCY = 34;

	int   check_errors = 0;
	int   monitor_errors = 0;
	logic armed = 1'b0;
	logic done_q = 1'b0;

	assign error_count = check_errors + monitor_errors;

	// Row r of block row i sees column (r + shift) mod CIRC of each block
	function automatic int failing_checks(input codeword_t w);
		int   count;
		logic parity;
		count = 0;
		for (int i = 0; i < BLK_ROWS; i++) begin
			for (int r = 0; r < CIRC; r++) begin
				parity = 1'b0;
				for (int j = 0; j < BLK_COLS; j++)
					parity ^= w[j * CIRC + (r + int'(shift_table[i][j])) % CIRC];
				if (parity)
					count++;
			end
		end
		return count;
	endfunction

	task automatic expect_value(input string name, input string what,
			input codeword_t expected, input codeword_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: %s expected %0h actual %0h", name, what, expected, actual);
			check_errors++;
		end
	endtask

	task automatic check_reset_state();
		expect_value("reset", "busy", '0, CODE_LEN'(busy));
		expect_value("reset", "done", '0, CODE_LEN'(done));
		expect_value("reset", "success", '0, CODE_LEN'(success));
		expect_value("reset", "iterations", '0, CODE_LEN'(iterations));
	endtask

	task automatic check_result(input string name, input codeword_t word, input logic is_cw,
			input int latency);
		int fails;
		fails = failing_checks(decoded);
		if (is_cw) begin
			expect_value(name, "success", CODE_LEN'(1), CODE_LEN'(success));
			expect_value(name, "iterations", '0, CODE_LEN'(iterations));
			expect_value(name, "decoded", word, decoded);
			expect_value(name, "latency", CODE_LEN'(CW_LATENCY), CODE_LEN'(latency));
		end else if (success === 1'b1) begin
			expect_value(name, "failing checks", '0, CODE_LEN'(fails));
			if (int'(iterations) < 1 || int'(iterations) > MAX_ITER) begin
				$display("FAILED %s: iterations expected 1 to %0d actual %0d", name, MAX_ITER,
					iterations);
				check_errors++;
			end
		end else begin
			expect_value(name, "iterations", CODE_LEN'(MAX_ITER), CODE_LEN'(iterations));
			if (fails == 0) begin
				$display("FAILED %s: failing checks expected nonzero actual 0", name);
				check_errors++;
			end
		end
	endtask

	task automatic report_timeout(input string name, input int cycles);
		$display("Test %s timed out: no done pulse within %0d cycles", name, cycles);
		check_errors++;
	endtask

	task automatic print_counts();
		$display("Error counts: %0d result, %0d protocol", check_errors, monitor_errors);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk) begin
		if (!rst) begin
			if (done && done_q) begin
				$display("Done stayed high for more than one cycle");
				monitor_errors++;
			end
			if (done && !armed) begin
				$display("Done pulsed with no decode in progress");
				monitor_errors++;
			end
			if (armed && !busy && !done) begin
				$display("Busy dropped before the decode finished");
				monitor_errors++;
			end
			if (done)
				armed <= 1'b0;
			else if (busy)
				armed <= 1'b1;
			done_q <= done;
		end
	end

endmodule

//--- tb_ldpc_decoder.sv
`timescale 1ns/1ps

module tb_ldpc_decoder
	import ldpc_pkg::*;
();

	localparam int NUM_TESTS    = 11;
	localparam int DONE_TIMEOUT = 5000;
	localparam int RESTART_AT   = 10;

	typedef struct packed {
		codeword_t word;
		logic      is_cw;
		logic      restart;
	} test_entry_t;

	logic              clk;
	logic              rst;
	logic              start;
	codeword_t         word_in;
	logic              busy;
	logic              done;
	logic              success;
	logic [ITER_W-1:0] iterations;
	codeword_t         decoded;
	int                error_count;

	test_entry_t tests [NUM_TESTS];
	string       test_name [NUM_TESTS];
	int          n_tests;
	int          seed;
	logic        timed_out;

	ldpc_decoder dut0 (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.word_in    (word_in),
		.busy       (busy),
		.done       (done),
		.success    (success),
		.iterations (iterations),
		.decoded    (decoded)
	);

	ldpc_checker chk0 (
		.clk         (clk),
		.rst         (rst),
		.busy        (busy),
		.done        (done),
		.success     (success),
		.iterations  (iterations),
		.decoded     (decoded),
		.error_count (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Even count of all-ones blocks satisfies every check
	function automatic codeword_t ones_blocks(input logic [BLK_COLS-1:0] mask);
		codeword_t w;
		w = '0;
		for (int j = 0; j < BLK_COLS; j++)
			if (mask[j])
				w[j * CIRC +: CIRC] = '1;
		return w;
	endfunction

	task automatic add_test(input string name, input codeword_t word, input logic is_cw,
			input logic restart);
		test_name[n_tests] = name;
		tests[n_tests] = '{word: word, is_cw: is_cw, restart: restart};
		n_tests++;
	endtask

	// Flip distinct bits of a codeword
	task automatic add_corrupted(input string name, input codeword_t base, input int flips,
			input logic restart);
		codeword_t w;
		int        pos;
		int        guard;
		w = base;
		for (int k = 0; k < flips; k++) begin
			guard = 0;
			do begin
				pos = int'($unsigned($random(seed)) % CODE_LEN);
				guard++;
			end while (w[pos] != base[pos] && guard < 100);
			w[pos] = ~w[pos];
		end
		add_test(name, w, 1'b0, restart);
	endtask

	task automatic run_test(input int idx);
		int   cycles;
		logic got_done;
		start = 1'b1;
		word_in = tests[idx].word;
		cycles = 0;
		got_done = 1'b0;
		while (!got_done && cycles < DONE_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
			// Second start while busy must be ignored
			if (tests[idx].restart && cycles == RESTART_AT) begin
				start = 1'b1;
				word_in = ~tests[idx].word;
			end else begin
				start = 1'b0;
			end
			got_done = done;
		end
		if (got_done) begin
			chk0.check_result(test_name[idx], tests[idx].word, tests[idx].is_cw, cycles);
		end else begin
			chk0.report_timeout(test_name[idx], cycles);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		word_in = '0;
		seed = 32'he5a9_8a71;
		n_tests = 0;
		timed_out = 1'b0;
		add_test("zero", '0, 1'b1, 1'b0);
		add_test("blk01", ones_blocks(5'b00011), 1'b1, 1'b0);
		add_test("blk24", ones_blocks(5'b10100), 1'b1, 1'b0);
		add_test("blk0123", ones_blocks(5'b01111), 1'b1, 1'b0);
		add_test("blk1234_restart", ones_blocks(5'b11110), 1'b1, 1'b1);
		add_corrupted("zero_flip1", '0, 1, 1'b0);
		add_corrupted("blk01_flip2", ones_blocks(5'b00011), 2, 1'b0);
		add_corrupted("blk24_flip3", ones_blocks(5'b10100), 3, 1'b0);
		add_corrupted("blk0123_flip1", ones_blocks(5'b01111), 1, 1'b0);
		add_corrupted("blk1234_flip2", ones_blocks(5'b11110), 2, 1'b0);
		add_corrupted("zero_flip3_restart", '0, 3, 1'b1);

		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		chk0.check_reset_state();
		for (int t = 0; t < n_tests && !timed_out; t++)
			run_test(t);

		chk0.print_counts();
		// Let the summed count settle
		#1;
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- ldpc_decoder.f
ldpc_pkg.sv
phase_sequencer.sv
edge_memory.sv
variable_node_unit.sv
check_node_unit.sv
ldpc_decoder.sv
ldpc_checker.sv
tb_ldpc_decoder.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ldpc_decoder \
	-f ldpc_decoder.f -Mdir obj_dir -o sim_ldpc_decoder

out=$(./obj_dir/sim_ldpc_decoder)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "TB PASSED"
